// ==== verilog/bpuPkg.sv ====
package bpuPkg;

    // datapath and table geometry
    localparam int XLen     = 32;
    localparam int PhtIdxW  = 6;
    localparam int PhtDepth = 1 << PhtIdxW;
    localparam int RegIdxW  = 5;
    localparam int OpW      = 6;

    localparam logic [XLen-1:0] ResetPc = 32'hbfc0_0000;   // boot rom vector

    // primary opcodes, instr[31:26]
    localparam logic [OpW-1:0] OpRegimm = 6'b000001;
    localparam logic [OpW-1:0] OpBeq    = 6'b000100;
    localparam logic [OpW-1:0] OpBne    = 6'b000101;
    localparam logic [OpW-1:0] OpBlez   = 6'b000110;
    localparam logic [OpW-1:0] OpBgtz   = 6'b000111;

    // rt codes under regimm
    localparam logic [RegIdxW-1:0] RtBltz = 5'b00000;
    localparam logic [RegIdxW-1:0] RtBgez = 5'b00001;

    // condition selected in execute
    typedef enum logic [2:0] {
        BrNone = 3'd0,
        BrEq   = 3'd1,
        BrNe   = 3'd2,
        BrLez  = 3'd3,
        BrGtz  = 3'd4,
        BrLtz  = 3'd5,
        BrGez  = 3'd6
    } brKind_t;

    // 2-bit saturating counter, msb set means predict taken
    typedef enum logic [1:0] {
        StrongNot   = 2'b00,
        WeakNot     = 2'b01,
        WeakTaken   = 2'b10,
        StrongTaken = 2'b11
    } ctr_t;

endpackage

// ==== verilog/branchIfs.sv ====
`timescale 1ns/1ps

// decode stage branch info, combinational within the cycle
interface predIf import bpuPkg::*; ();

    logic            valid;
    brKind_t         kind;
    logic            predTaken;
    logic [XLen-1:0] target;
    logic [XLen-1:0] pc;

    modport drv (
        output valid, kind, predTaken, target, pc
    );

    modport rcv (
        input valid, kind, predTaken, target, pc
    );

endinterface

// execute stage outcome
interface resolveIf import bpuPkg::*; ();

    logic               resolved;
    logic               actualTaken;
    logic               mispredict;
    logic [XLen-1:0]    recoverPc;
    logic [PhtIdxW-1:0] updIdx;     // table slot of the branch in execute

    modport drv (
        output resolved, actualTaken, mispredict, recoverPc, updIdx
    );

    modport rcv (
        input resolved, actualTaken, mispredict, recoverPc, updIdx
    );

endinterface

// ==== verilog/branchPredict.sv ====
`timescale 1ns/1ps

module branchPredict import bpuPkg::*; (
    input  logic            clk,
    input  logic            arstN_i,
    input  logic            decValid_i,
    input  logic [XLen-1:0] decPc_i,
    input  logic [XLen-1:0] decInstr_i,
    predIf.drv              pred,
    resolveIf.rcv           upd
);

    logic [OpW-1:0]     opcode;
    logic [RegIdxW-1:0] rtField;
    logic [15:0]        offset;
    logic [XLen-1:0]    offsetExt;
    logic [PhtIdxW-1:0] decIdx;
    brKind_t            decKind;
    ctr_t               pht [PhtDepth];
    ctr_t               curCtr;
    ctr_t               nextCtr;

    assign opcode  = decInstr_i[31:26];
    assign rtField = decInstr_i[20:16];
    assign offset  = decInstr_i[15:0];
    assign decIdx  = decPc_i[PhtIdxW+1:2];   // word aligned pc, drop low bits

    always_comb begin
        decKind = BrNone;
        case (opcode)
            OpBeq:  decKind = BrEq;
            OpBne:  decKind = BrNe;
            OpBlez: decKind = BrLez;
            OpBgtz: decKind = BrGtz;
            OpRegimm: begin
                // link variants fall through as non-branch
                if (rtField == RtBltz) begin
                    decKind = BrLtz;
                end else if (rtField == RtBgez) begin
                    decKind = BrGez;
                end
            end
            default: decKind = BrNone;
        endcase
    end

    // offset is in words
    assign offsetExt = {{(XLen-18){offset[15]}}, offset, 2'b00};

    assign pred.valid     = decValid_i;
    assign pred.kind      = decKind;
    assign pred.pc        = decPc_i;
    assign pred.target    = decPc_i + 32'd4 + offsetExt;
    assign pred.predTaken = decValid_i && (decKind != BrNone) && pht[decIdx][1];

    // saturating step for the branch leaving execute
    always_comb begin
        curCtr  = pht[upd.updIdx];
        nextCtr = curCtr;
        case (curCtr)
            StrongNot:   nextCtr = upd.actualTaken ? WeakNot     : StrongNot;
            WeakNot:     nextCtr = upd.actualTaken ? WeakTaken   : StrongNot;
            WeakTaken:   nextCtr = upd.actualTaken ? StrongTaken : WeakNot;
            StrongTaken: nextCtr = upd.actualTaken ? StrongTaken : WeakTaken;
            default:     nextCtr = WeakNot;
        endcase
    end

    // write lands at the edge ending execute, same-cycle lookup sees old value
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            for (int i = 0; i < PhtDepth; i++) begin
                pht[i] <= WeakNot;
            end
        end else if (upd.resolved) begin
            pht[upd.updIdx] <= nextCtr;
        end
    end

endmodule

// ==== verilog/branchJudge.sv ====
`timescale 1ns/1ps

module branchJudge import bpuPkg::*; (
    input  logic            clk,
    input  logic            arstN_i,
    input  logic [XLen-1:0] exRsValue_i,   // already forwarded
    input  logic [XLen-1:0] exRtValue_i,
    predIf.rcv              pred,
    resolveIf.drv           res
);

    brKind_t                exKind;
    logic                   exPredTaken;
    logic [XLen-1:0]        exTarget;
    logic [XLen-1:0]        exPc;
    logic signed [XLen-1:0] rsVal;
    logic signed [XLen-1:0] rtVal;
    logic                   resolved;
    logic                   taken;

    // decode to execute, kind doubles as the valid bit
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            exKind      <= BrNone;
            exPredTaken <= 1'b0;
        end else begin
            exKind      <= pred.valid ? pred.kind : BrNone;
            exPredTaken <= pred.valid & pred.predTaken;
        end
    end

    always_ff @(posedge clk) begin
        if (pred.valid) begin
            exTarget <= pred.target;
            exPc     <= pred.pc;
        end
    end

    assign rsVal = exRsValue_i;
    assign rtVal = exRtValue_i;

    always_comb begin
        case (exKind)
            BrEq:    taken = (rsVal == rtVal);
            BrNe:    taken = (rsVal != rtVal);
            BrLez:   taken = (rsVal <= 0);
            BrGtz:   taken = (rsVal > 0);
            BrLtz:   taken = rsVal[XLen-1];   // sign bit
            BrGez:   taken = !rsVal[XLen-1];
            default: taken = 1'b0;
        endcase
    end

    assign resolved = (exKind != BrNone);

    assign res.resolved    = resolved;
    assign res.actualTaken = taken;
    assign res.mispredict  = resolved && (exPredTaken != taken);
    // not taken resumes after the delay slot
    assign res.recoverPc   = taken ? exTarget : exPc + 32'd8;
    assign res.updIdx      = exPc[PhtIdxW+1:2];

endmodule

// ==== verilog/pcSelect.sv ====
`timescale 1ns/1ps

module pcSelect import bpuPkg::*; (
    input  logic            clk,
    input  logic            arstN_i,
    predIf.rcv              pred,
    resolveIf.rcv           res,
    output logic [XLen-1:0] fetchPc_o,
    output logic [XLen-1:0] pcNext_o
);

    logic [XLen-1:0] fetchPc;
    logic [XLen-1:0] pcPlus4;
    logic [XLen-1:0] pcNext;
    logic            decTaken;

    assign pcPlus4  = fetchPc + 32'd4;
    assign decTaken = pred.valid && (pred.kind != BrNone) && pred.predTaken;

    // execute recovery beats the younger decode prediction
    always_comb begin
        if (res.mispredict) begin
            pcNext = res.recoverPc;
        end else if (decTaken) begin
            pcNext = pred.target;
        end else begin
            pcNext = pcPlus4;
        end
    end

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            fetchPc <= ResetPc;
        end else begin
            fetchPc <= pcNext;   // no stalls, loads every cycle
        end
    end

    assign fetchPc_o = fetchPc;
    assign pcNext_o  = pcNext;

endmodule

// ==== verilog/bpuFront.sv ====
`timescale 1ns/1ps

module bpuFront import bpuPkg::*; (
    input  logic            clk,
    input  logic            arstN_i,
    input  logic            decValid_i,
    input  logic [XLen-1:0] decPc_i,
    input  logic [XLen-1:0] decInstr_i,
    input  logic [XLen-1:0] exRsValue_i,
    input  logic [XLen-1:0] exRtValue_i,
    output logic [XLen-1:0] fetchPc_o,
    output logic [XLen-1:0] pcNext_o,
    output logic            predTaken_o,
    output logic            exBranch_o,
    output logic            actualTaken_o,
    output logic            mispredict_o
);

    predIf    predBus ();
    resolveIf resBus ();

    branchPredict branchPredict0 (
        .clk        (clk),
        .arstN_i    (arstN_i),
        .decValid_i (decValid_i),
        .decPc_i    (decPc_i),
        .decInstr_i (decInstr_i),
        .pred       (predBus),
        .upd        (resBus)      // counter update from execute
    );

    branchJudge branchJudge0 (
        .clk         (clk),
        .arstN_i     (arstN_i),
        .exRsValue_i (exRsValue_i),
        .exRtValue_i (exRtValue_i),
        .pred        (predBus),
        .res         (resBus)
    );

    pcSelect pcSelect0 (
        .clk       (clk),
        .arstN_i   (arstN_i),
        .pred      (predBus),
        .res       (resBus),
        .fetchPc_o (fetchPc_o),
        .pcNext_o  (pcNext_o)
    );

    assign predTaken_o   = predBus.predTaken;
    assign exBranch_o    = resBus.resolved;
    assign actualTaken_o = resBus.actualTaken;
    assign mispredict_o  = resBus.mispredict;

endmodule

// ==== sim/bpuFront_asserts.sv ====
`timescale 1ns/1ps

module bpuFront_asserts import bpuPkg::*; (
    input logic            clk,
    input logic            arstN_i,
    input logic            exBranch_i,
    input logic            mispredict_i,
    input logic [XLen-1:0] fetchPc_i,
    input logic [XLen-1:0] pcNext_i
);

    // a mispredict needs a branch in execute
    mispredictNeedsBranch: assert property (
        @(posedge clk) disable iff (!arstN_i) mispredict_i |-> exBranch_i
    ) else $error("mispredict_o high without exBranch_o");

    quietInReset: assert property (
        @(posedge clk) !arstN_i |-> !exBranch_i
    ) else $error("exBranch_o high while reset is asserted");

    // fetch pc loads every edge, no stalls
    fetchFollowsNext: assert property (
        @(posedge clk) disable iff (!arstN_i) $past(arstN_i) |-> fetchPc_i == $past(pcNext_i)
    ) else $error("fetchPc_o differs from the previous pcNext_o");

endmodule

bind bpuFront bpuFront_asserts asserts0 (
    .clk          (clk),
    .arstN_i      (arstN_i),
    .exBranch_i   (exBranch_o),
    .mispredict_i (mispredict_o),
    .fetchPc_i    (fetchPc_o),
    .pcNext_i     (pcNext_o)
);

// ==== include/bpuTbModel.svh ====
`ifndef BPU_TB_MODEL_SVH
`define BPU_TB_MODEL_SVH

// expects bpuPkg imported by the including module
ctr_t            mdlPht [PhtDepth];
brKind_t         mdlExKind;      // BrNone when execute is empty
logic            mdlExPred;
logic [XLen-1:0] mdlExTarget;
logic [XLen-1:0] mdlExPc;
logic [XLen-1:0] mdlFetchPc;

function automatic void mdlReset();
    for (int i = 0; i < PhtDepth; i++) begin
        mdlPht[i] = WeakNot;
    end
    mdlExKind  = BrNone;
    mdlExPred  = 1'b0;
    mdlFetchPc = ResetPc;
endfunction

function automatic brKind_t mdlKind(logic [XLen-1:0] instr);
    case (instr[31:26])
        OpBeq:    return BrEq;
        OpBne:    return BrNe;
        OpBlez:   return BrLez;
        OpBgtz:   return BrGtz;
        OpRegimm: return (instr[20:16] == RtBltz) ? BrLtz :
                         (instr[20:16] == RtBgez) ? BrGez : BrNone;
        default:  return BrNone;
    endcase
endfunction

function automatic logic [XLen-1:0] mdlTarget(logic [XLen-1:0] pc, logic [XLen-1:0] instr);
    return pc + 32'd4 + {{(XLen-18){instr[15]}}, instr[15:0], 2'b00};
endfunction

function automatic logic mdlPred(logic valid, logic [XLen-1:0] pc, logic [XLen-1:0] instr);
    return valid && (mdlKind(instr) != BrNone) && mdlPht[pc[PhtIdxW+1:2]][1];
endfunction

function automatic logic mdlTaken(brKind_t kind, logic signed [XLen-1:0] rs,
                                  logic signed [XLen-1:0] rt);
    case (kind)
        BrEq:    return rs == rt;
        BrNe:    return rs != rt;
        BrLez:   return rs <= 0;
        BrGtz:   return rs > 0;
        BrLtz:   return rs < 0;
        BrGez:   return rs >= 0;
        default: return 1'b0;
    endcase
endfunction

function automatic logic mdlMispredict(logic [XLen-1:0] rs, logic [XLen-1:0] rt);
    return (mdlExKind != BrNone) && (mdlTaken(mdlExKind, rs, rt) != mdlExPred);
endfunction

function automatic logic [XLen-1:0] mdlPcNext(logic valid, logic [XLen-1:0] pc,
        logic [XLen-1:0] instr, logic [XLen-1:0] rs, logic [XLen-1:0] rt);
    if (mdlMispredict(rs, rt)) begin
        return mdlTaken(mdlExKind, rs, rt) ? mdlExTarget : mdlExPc + 32'd8;
    end
    if (mdlPred(valid, pc, instr)) begin
        return mdlTarget(pc, instr);
    end
    return mdlFetchPc + 32'd4;
endfunction

// one clock edge, call with the inputs of the cycle that edge ends
function automatic void mdlStep(logic valid, logic [XLen-1:0] pc, logic [XLen-1:0] instr,
                                logic [XLen-1:0] rs, logic [XLen-1:0] rt);
    logic [PhtIdxW-1:0] idx;
    logic               taken;
    logic               pred;
    logic [XLen-1:0]    nextPc;
    idx    = mdlExPc[PhtIdxW+1:2];
    taken  = mdlTaken(mdlExKind, rs, rt);
    pred   = mdlPred(valid, pc, instr);   // old counter, before the update
    nextPc = mdlPcNext(valid, pc, instr, rs, rt);
    if (mdlExKind != BrNone) begin
        if (taken && mdlPht[idx] != StrongTaken) begin
            mdlPht[idx] = ctr_t'(mdlPht[idx] + 1);
        end else if (!taken && mdlPht[idx] != StrongNot) begin
            mdlPht[idx] = ctr_t'(mdlPht[idx] - 1);
        end
    end
    mdlExKind   = valid ? mdlKind(instr) : BrNone;
    mdlExPred   = pred;
    mdlExTarget = mdlTarget(pc, instr);
    mdlExPc     = pc;
    mdlFetchPc  = nextPc;
endfunction

`endif

// ==== sim/bpuFront_tb.sv ====
`timescale 1ns/1ps

module bpuFront_tb import bpuPkg::*; ();

    logic            clk;
    logic            arstN_i;
    logic            decValid_i;
    logic [XLen-1:0] decPc_i;
    logic [XLen-1:0] decInstr_i;
    logic [XLen-1:0] exRsValue_i;
    logic [XLen-1:0] exRtValue_i;
    logic [XLen-1:0] fetchPc_o;
    logic [XLen-1:0] pcNext_o;
    logic            predTaken_o;
    logic            exBranch_o;
    logic            actualTaken_o;
    logic            mispredict_o;

    integer seed = 32'h3e75_a4fb;
    int     checkCnt = 0;
    int     errCnt = 0;
    int     testCnt = 0;
    int     chkBase = 0;
    int     errBase = 0;

    `include "bpuTbModel.svh"

    bpuFront DUT (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    initial begin
        arstN_i = 1'b0;
        repeat (8) @(negedge clk);
        arstN_i = 1'b1;
    end

    // hard stop for a stuck run
    initial begin
        #200_000;
        $display("timeout, the run did not reach its end");
        $display("Regression failed");
        $finish;
    end

    task automatic checkPc(input string name, input logic [XLen-1:0] got,
                           input logic [XLen-1:0] exp);
        checkCnt++;
        if (got !== exp) begin
            errCnt++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        checkCnt++;
        if (got !== exp) begin
            errCnt++;
            $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic endTest(input string name);
        testCnt++;
        $display("test %0d %s: %0d checks, %0d errors", testCnt, name,
                 checkCnt - chkBase, errCnt - errBase);
        chkBase = checkCnt;
        errBase = errCnt;
    endtask

    task automatic randomStim(output logic v, output logic [XLen-1:0] pc,
                              output logic [XLen-1:0] instr, output logic [XLen-1:0] rs,
                              output logic [XLen-1:0] rt);
        int unsigned        pick;
        int unsigned        mode;
        logic [15:0]        off;
        logic [RegIdxW-1:0] rsF;
        logic [RegIdxW-1:0] rtF;
        pick = $unsigned($random(seed)) % 8;
        off  = 16'($unsigned($random(seed)) % 16) - 16'd8;   // -8..7 words
        rsF  = 5'($random(seed));
        rtF  = 5'($random(seed));
        case (pick)
            0: instr = {OpBeq, rsF, rtF, off};
            1: instr = {OpBne, rsF, rtF, off};
            2: instr = {OpBlez, rsF, 5'd0, off};
            3: instr = {OpBgtz, rsF, 5'd0, off};
            4: instr = {OpRegimm, rsF, RtBltz, off};
            5: instr = {OpRegimm, rsF, RtBgez, off};
            6: instr = {6'b001001, rsF, rtF, off};          // addiu
            default: instr = {OpRegimm, rsF, 5'b10001, off}; // bgezal, not a branch here
        endcase
        v  = ($unsigned($random(seed)) % 8) != 0;
        // few pcs, 0x100 apart alias in the table
        pc = 32'h0040_0000 + (($unsigned($random(seed)) % 4) << 8)
                           + (($unsigned($random(seed)) % 4) << 2);
        mode = $unsigned($random(seed)) % 4;
        rs   = $random(seed);
        rt   = $random(seed);
        if (mode == 0) begin
            rt = rs;
        end else if (mode == 1) begin
            rs = '0;
        end else if (mode == 2) begin
            rs = '0;
            rt = '0;
        end
    endtask

    // drive at the falling edge, check mid cycle, then advance the model
    task automatic runCycle(input logic v, input logic [XLen-1:0] pc,
                            input logic [XLen-1:0] instr, input logic [XLen-1:0] rs,
                            input logic [XLen-1:0] rt);
        @(negedge clk);
        decValid_i  = v;
        decPc_i     = pc;
        decInstr_i  = instr;
        exRsValue_i = rs;
        exRtValue_i = rt;
        #10;
        checkBit("predTaken_o", predTaken_o, mdlPred(v, pc, instr));
        checkBit("exBranch_o", exBranch_o, mdlExKind != BrNone);
        checkBit("actualTaken_o", actualTaken_o, mdlTaken(mdlExKind, rs, rt));
        checkBit("mispredict_o", mispredict_o, mdlMispredict(rs, rt));
        checkPc("pcNext_o", pcNext_o, mdlPcNext(v, pc, instr, rs, rt));
        checkPc("fetchPc_o", fetchPc_o, mdlFetchPc);
        mdlStep(v, pc, instr, rs, rt);
    endtask

    initial begin
        int              waited;
        logic            v;
        logic [XLen-1:0] pc;
        logic [XLen-1:0] instr;
        logic [XLen-1:0] rs;
        logic [XLen-1:0] rt;
        decValid_i  = 1'b0;
        decPc_i     = '0;
        decInstr_i  = '0;
        exRsValue_i = '0;
        exRtValue_i = '0;
        mdlReset();
        waited = 0;
        while (arstN_i !== 1'b1 && waited < 2000) begin
            #1;
            waited++;
        end
        if (arstN_i !== 1'b1) begin
            $display("reset was not released in time");
            $display("Regression failed");
            $finish;
        end

        #10;
        checkPc("fetchPc_o", fetchPc_o, ResetPc);
        checkBit("exBranch_o", exBranch_o, 1'b0);
        checkBit("mispredict_o", mispredict_o, 1'b0);
        checkPc("pcNext_o", pcNext_o, mdlPcNext(1'b0, '0, '0, '0, '0));
        mdlStep(1'b0, '0, '0, '0, '0);
        endTest("reset");

        // same pc back to back, counter climbs then falls to both ends
        for (int i = 0; i < 6; i++) begin
            runCycle(1'b1, 32'h0040_0010, {OpBeq, 5'd3, 5'd4, 16'hfff0}, 32'd5, 32'd5);
        end
        for (int i = 0; i < 6; i++) begin
            runCycle(1'b1, 32'h0040_0010, {OpBne, 5'd3, 5'd4, 16'h0004}, 32'd5, 32'd5);
        end
        runCycle(1'b0, '0, '0, 32'd5, 32'd5);
        endTest("saturate");

        for (int i = 0; i < 16; i++) begin
            randomStim(v, pc, instr, rs, rt);
            pc = (i % 2 == 1) ? 32'h0040_0020 : 32'h0040_0120;
            runCycle(1'b1, pc, instr, rs, rt);
        end
        endTest("alias");

        for (int i = 0; i < 400; i++) begin
            randomStim(v, pc, instr, rs, rt);
            runCycle(v, pc, instr, rs, rt);
        end
        endTest("random");

        $display("tests %0d, checks %0d, errors %0d", testCnt, checkCnt, errCnt);
        if (errCnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== bpuFront.f ====
+incdir+include
verilog/bpuPkg.sv
verilog/branchIfs.sv
verilog/branchPredict.sv
verilog/branchJudge.sv
verilog/pcSelect.sv
verilog/bpuFront.sv
sim/bpuFront_asserts.sv
sim/bpuFront_tb.sv

// ==== Makefile ====
# Verilator build and run for bpuFront

VERILATOR ?= verilator
TOP       ?= bpuFront_tb
FILELIST  ?= bpuFront.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Regression failed" $(LOG) || ! grep -q "Regression passed" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; \
		exit 1; \
	else \
		echo "simulation PASSED"; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
